/* logic/issue_pkg.sv */
package issue_pkg;

    parameter int REG_ADDR_WIDTH = 5; // Register index width, x0 to x31.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operation encoding
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        OP_ADD   = 3'd0, // rd = rs1 + rs2.
        OP_SUB   = 3'd1, // rd = rs1 - rs2.
        OP_AND   = 3'd2,
        OP_OR    = 3'd3,
        OP_XOR   = 3'd4,
        OP_ADDI  = 3'd5, // rd = rs1 + imm.
        OP_LOAD  = 3'd6, // rd = mem[rs1 + imm].
        OP_STORE = 3'd7  // mem[rs1 + imm] = rs2.
    } op_t;

    // Operand source picked by the hazard unit.
    typedef enum logic [1:0] {
        FWD_RF  = 2'd0, // Register file, which already covers WB by write-through.
        FWD_MEM = 2'd1  // ALU result held in the MEM stage.
    } fwd_sel_t;

    // Every op produces a register result except a store.
    function automatic logic op_writes_rd(input op_t op);
        return op != OP_STORE;
    endfunction

endpackage

/* logic/issue_hazard.sv */
`timescale 1ns/1ps

module issue_hazard import issue_pkg::*; (
    input  logic                      in_valid,
    input  op_t                       in_op,
    input  logic [REG_ADDR_WIDTH-1:0] in_rs1,
    input  logic [REG_ADDR_WIDTH-1:0] in_rs2,
    input  logic                      ex_valid,
    input  logic [REG_ADDR_WIDTH-1:0] ex_rd,
    input  logic                      ex_wr,
    input  logic                      mem_valid,
    input  logic [REG_ADDR_WIDTH-1:0] mem_rd,
    input  logic                      mem_wr,
    input  logic                      mem_is_load,
    output logic                      stall,
    output fwd_sel_t                  fwd1,
    output fwd_sel_t                  fwd2
);

    logic chk1; // Operand 1 carries a real dependency.
    logic chk2;
    logic ex_hit1; // A source matches the instruction in EX.
    logic ex_hit2;
    logic ld_hit1; // A source matches a load still in MEM.
    logic ld_hit2;
    logic alu_hit1; // A source matches an ALU result ready in MEM.
    logic alu_hit2;

    // x0 never holds a dependency, and ADDI and LOAD leave rs2 unread.
    assign chk1 = in_rs1 != '0;
    assign chk2 = (in_rs2 != '0) && (in_op != OP_ADDI) && (in_op != OP_LOAD);

    assign ex_hit1 = chk1 && ex_valid && ex_wr && (in_rs1 == ex_rd);
    assign ex_hit2 = chk2 && ex_valid && ex_wr && (in_rs2 == ex_rd);

    assign ld_hit1 = chk1 && mem_valid && mem_is_load && (in_rs1 == mem_rd);
    assign ld_hit2 = chk2 && mem_valid && mem_is_load && (in_rs2 == mem_rd);

    assign alu_hit1 = chk1 && mem_valid && mem_wr && !mem_is_load && (in_rs1 == mem_rd);
    assign alu_hit2 = chk2 && mem_valid && mem_wr && !mem_is_load && (in_rs2 == mem_rd);

    // An EX result is not ready yet; a load waits until its data reaches WB.
    assign stall = in_valid && (ex_hit1 || ex_hit2 || ld_hit1 || ld_hit2);

    assign fwd1 = alu_hit1 ? FWD_MEM : FWD_RF; // EX match already stalls.
    assign fwd2 = alu_hit2 ? FWD_MEM : FWD_RF;

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file import issue_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [REG_ADDR_WIDTH-1:0] raddr1,
    input  logic [REG_ADDR_WIDTH-1:0] raddr2,
    output logic [XLEN-1:0]           rdata1,
    output logic [XLEN-1:0]           rdata2,
    input  logic                      we,
    input  logic [REG_ADDR_WIDTH-1:0] waddr,
    input  logic [XLEN-1:0]           wdata
);

    localparam int NUM_REGS = 1 << REG_ADDR_WIDTH;

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            wr_live; // A write to a real register this cycle.

    assign wr_live = we && (waddr != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0; // Whole file starts at zero.
            end
        end else if (wr_live) begin
            regs[waddr] <= wdata; // x0 is never written, so it reads zero.
        end
    end

    // Write-through so a WB value is visible to the stage reading this cycle.
    assign rdata1 = (wr_live && raddr1 == waddr) ? wdata : regs[raddr1];
    assign rdata2 = (wr_live && raddr2 == waddr) ? wdata : regs[raddr2];

endmodule

/* logic/data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
    parameter int XLEN       = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic [$clog2(DMEM_DEPTH)-1:0] addr,
    input  logic                          we,
    input  logic [XLEN-1:0]               wdata,
    output logic [XLEN-1:0]               rdata
);

    logic [XLEN-1:0] mem [DMEM_DEPTH];

    // One port. Read data follows the address by one cycle.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr]; // Old contents on a write, which a store never reads.
    end

endmodule

/* logic/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage import issue_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  op_t                       in_op,
    input  logic [REG_ADDR_WIDTH-1:0] in_rd,
    input  logic [REG_ADDR_WIDTH-1:0] in_rs1,
    input  logic [REG_ADDR_WIDTH-1:0] in_rs2,
    input  logic [XLEN-1:0]           in_imm,
    input  logic                      stall,
    input  fwd_sel_t                  fwd1,
    input  fwd_sel_t                  fwd2,
    output logic [REG_ADDR_WIDTH-1:0] rf_raddr1,
    output logic [REG_ADDR_WIDTH-1:0] rf_raddr2,
    input  logic [XLEN-1:0]           rf_rdata1,
    input  logic [XLEN-1:0]           rf_rdata2,
    input  logic [XLEN-1:0]           mem_fwd_data,
    output logic                      iss_valid,
    output op_t                       iss_op,
    output logic [REG_ADDR_WIDTH-1:0] iss_rd,
    output logic [XLEN-1:0]           iss_a,
    output logic [XLEN-1:0]           iss_b,
    output logic [XLEN-1:0]           iss_imm
);

    logic            run; // Set on the first edge after reset.
    logic            take; // Input transfer this cycle.
    logic [XLEN-1:0] opnd_a;
    logic [XLEN-1:0] opnd_b;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake and operand read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    assign in_ready = run && !stall; // Held low while reset is asserted.
    assign take     = in_valid && in_ready;

    assign rf_raddr1 = in_rs1; // The register file answers in the same cycle.
    assign rf_raddr2 = in_rs2;

    assign opnd_a = (fwd1 == FWD_MEM) ? mem_fwd_data : rf_rdata1;
    assign opnd_b = (fwd2 == FWD_MEM) ? mem_fwd_data : rf_rdata2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // EX-entry register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= take; // A stall or idle cycle sends a bubble.
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            iss_op  <= in_op;
            iss_rd  <= in_rd;
            iss_a   <= opnd_a;
            iss_b   <= opnd_b;
            iss_imm <= in_imm;
        end
    end

endmodule

/* logic/exec_pipe.sv */
`timescale 1ns/1ps

module exec_pipe import issue_pkg::*; #(
    parameter int XLEN       = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          iss_valid,
    input  op_t                           iss_op,
    input  logic [REG_ADDR_WIDTH-1:0]     iss_rd,
    input  logic [XLEN-1:0]               iss_a,
    input  logic [XLEN-1:0]               iss_b,
    input  logic [XLEN-1:0]               iss_imm,
    output logic                          ex_valid,
    output logic [REG_ADDR_WIDTH-1:0]     ex_rd,
    output logic                          ex_wr,
    output logic                          mem_valid,
    output logic [REG_ADDR_WIDTH-1:0]     mem_rd,
    output logic                          mem_wr,
    output logic                          mem_is_load,
    output logic [XLEN-1:0]               mem_fwd_data,
    output logic [$clog2(DMEM_DEPTH)-1:0] ram_addr,
    output logic                          ram_we,
    output logic [XLEN-1:0]               ram_wdata,
    input  logic [XLEN-1:0]               ram_rdata,
    output logic                          rf_we,
    output logic [REG_ADDR_WIDTH-1:0]     rf_waddr,
    output logic [XLEN-1:0]               rf_wdata,
    output logic                          wb_valid,
    output logic [REG_ADDR_WIDTH-1:0]     wb_rd,
    output logic [XLEN-1:0]               wb_data
);

    localparam int ADDR_W = $clog2(DMEM_DEPTH);

    logic [XLEN-1:0]   ex_result; // ALU result, or store data for a store.
    logic [XLEN-1:0]   ex_sum; // Base plus offset for addi, load and store.
    logic [ADDR_W-1:0] ex_addr;

    logic              mem_is_store;
    logic [XLEN-1:0]   mem_result;
    logic [ADDR_W-1:0] mem_addr;

    logic              wb_vld_q;
    logic              wb_load_q;
    logic [REG_ADDR_WIDTH-1:0] wb_rd_q;
    logic [XLEN-1:0]   wb_result_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // EX stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign ex_valid = iss_valid; // The EX-entry register is the EX stage.
    assign ex_rd    = iss_rd;
    assign ex_wr    = op_writes_rd(iss_op);

    assign ex_sum  = iss_a + iss_imm;
    assign ex_addr = ADDR_W'(ex_sum % DMEM_DEPTH); // Word address wraps at the depth.

    always_comb begin
        case (iss_op)
            OP_ADD:   ex_result = iss_a + iss_b;
            OP_SUB:   ex_result = iss_a - iss_b;
            OP_AND:   ex_result = iss_a & iss_b;
            OP_OR:    ex_result = iss_a | iss_b;
            OP_XOR:   ex_result = iss_a ^ iss_b;
            OP_STORE: ex_result = iss_b; // Carried to MEM as write data.
            default:  ex_result = ex_sum; // ADDI; a load ignores it.
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // MEM stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_rd       <= iss_rd;
        mem_wr       <= op_writes_rd(iss_op);
        mem_is_load  <= iss_op == OP_LOAD;
        mem_is_store <= iss_op == OP_STORE;
        mem_result   <= ex_result;
        mem_addr     <= ex_addr;
    end

    assign mem_fwd_data = mem_result; // Used only for an ALU op in MEM.

    // The RAM read or write happens at the edge that ends the MEM cycle.
    assign ram_addr  = mem_addr;
    assign ram_we    = mem_valid && mem_is_store;
    assign ram_wdata = mem_result;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // WB stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_vld_q <= 1'b0;
        end else begin
            wb_vld_q <= mem_valid && mem_wr && (mem_rd != '0); // No pulse for x0.
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_q     <= mem_rd;
        wb_load_q   <= mem_is_load;
        wb_result_q <= mem_result;
    end

    assign wb_valid = wb_vld_q; // One cycle per result.
    assign wb_rd    = wb_rd_q;
    assign wb_data  = wb_load_q ? ram_rdata : wb_result_q;

    assign rf_we    = wb_vld_q; // Written at the edge that ends WB.
    assign rf_waddr = wb_rd_q;
    assign rf_wdata = wb_data;

endmodule

/* logic/issue_top.sv */
`timescale 1ns/1ps

module issue_top import issue_pkg::*; #(
    parameter int XLEN       = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  op_t                       in_op,
    input  logic [REG_ADDR_WIDTH-1:0] in_rd,
    input  logic [REG_ADDR_WIDTH-1:0] in_rs1,
    input  logic [REG_ADDR_WIDTH-1:0] in_rs2,
    input  logic [XLEN-1:0]           in_imm,
    output logic                      wb_valid,
    output logic [REG_ADDR_WIDTH-1:0] wb_rd,
    output logic [XLEN-1:0]           wb_data
);

    localparam int ADDR_W = $clog2(DMEM_DEPTH);

    logic                      stall;
    fwd_sel_t                  fwd1, fwd2;
    logic [REG_ADDR_WIDTH-1:0] rf_raddr1, rf_raddr2, rf_waddr;
    logic [XLEN-1:0]           rf_rdata1, rf_rdata2, rf_wdata;
    logic                      rf_we;
    logic                      iss_valid;
    op_t                       iss_op;
    logic [REG_ADDR_WIDTH-1:0] iss_rd;
    logic [XLEN-1:0]           iss_a, iss_b, iss_imm;
    logic                      ex_valid, ex_wr;
    logic [REG_ADDR_WIDTH-1:0] ex_rd, mem_rd;
    logic                      mem_valid, mem_wr, mem_is_load;
    logic [XLEN-1:0]           mem_fwd_data;
    logic [ADDR_W-1:0]         ram_addr;
    logic                      ram_we;
    logic [XLEN-1:0]           ram_wdata, ram_rdata;

    issue_stage #(.XLEN(XLEN)) u_issue (.*);

    issue_hazard u_hazard (.*);

    reg_file #(.XLEN(XLEN)) u_rf (
        .clk, .rst_n,
        .raddr1(rf_raddr1), .raddr2(rf_raddr2),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    exec_pipe #(.XLEN(XLEN), .DMEM_DEPTH(DMEM_DEPTH)) u_exec (.*);

    data_ram #(.XLEN(XLEN), .DMEM_DEPTH(DMEM_DEPTH)) u_ram (
        .clk,
        .addr(ram_addr), .we(ram_we), .wdata(ram_wdata), .rdata(ram_rdata)
    );

endmodule

/* testbench/tb_issue_top.sv */
`timescale 1ns/1ps

module tb_issue_top import issue_pkg::*;;

    localparam int XLEN       = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int TIMEOUT    = 50; // Cycles any single wait may take.

    logic                      clk;
    logic                      rst_n;
    logic                      in_valid;
    logic                      in_ready;
    op_t                       in_op;
    logic [REG_ADDR_WIDTH-1:0] in_rd;
    logic [REG_ADDR_WIDTH-1:0] in_rs1;
    logic [REG_ADDR_WIDTH-1:0] in_rs2;
    logic [XLEN-1:0]           in_imm;
    logic                      wb_valid;
    logic [REG_ADDR_WIDTH-1:0] wb_rd;
    logic [XLEN-1:0]           wb_data;

    integer seed;
    int     cyc = 0; // Counts rising edges.
    int     errors = 0;
    int     timeouts = 0;

    logic [XLEN-1:0]           reg_model [1 << REG_ADDR_WIDTH];
    logic [XLEN-1:0]           mem_model [DMEM_DEPTH];
    logic [REG_ADDR_WIDTH-1:0] exp_rd [$];
    logic [XLEN-1:0]           exp_data [$];
    int                        exp_cyc [$]; // Cycle in which the pulse must show.
    logic [REG_ADDR_WIDTH-1:0] act_rd [$];
    logic [XLEN-1:0]           act_data [$];
    int                        act_cyc [$];

    issue_top #(.XLEN(XLEN), .DMEM_DEPTH(DMEM_DEPTH)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period.
    end

    always @(posedge clk) cyc <= cyc + 1;

    // Writeback collector, sampled mid-cycle where the outputs are stable.
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && wb_valid) begin
                act_rd.push_back(wb_rd);
                act_data.push_back(wb_data);
                act_cyc.push_back(cyc);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Utilities and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic next_rand(output logic [31:0] r);
        r = $random(seed);
    endtask

    // Applies one accepted instruction in issue order.
    task automatic apply_model(input op_t op, input logic [REG_ADDR_WIDTH-1:0] rd, rs1, rs2,
                               input logic [XLEN-1:0] imm, input int acc);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] sum;
        logic [XLEN-1:0] res;
        int              idx;
        a   = reg_model[rs1];
        b   = reg_model[rs2];
        sum = a + imm;
        idx = int'(sum % XLEN'(DMEM_DEPTH)); // Word address wraps at the depth.
        res = '0;
        case (op)
            OP_ADD:   res = a + b;
            OP_SUB:   res = a - b;
            OP_AND:   res = a & b;
            OP_OR:    res = a | b;
            OP_XOR:   res = a ^ b;
            OP_ADDI:  res = sum;
            OP_LOAD:  res = mem_model[idx];
            default:  mem_model[idx] = b; // Store.
        endcase
        if (op != OP_STORE && rd != '0) begin
            reg_model[rd] = res;
            exp_rd.push_back(rd);
            exp_data.push_back(res);
            exp_cyc.push_back(acc + 3); // Pulse three cycles after the transfer.
        end
    endtask

    // Called 1 ns after a rising edge, and returns at the same point.
    task automatic send_instr(input string name, input op_t op,
                              input logic [REG_ADDR_WIDTH-1:0] rd, rs1, rs2,
                              input logic [XLEN-1:0] imm, output int waited);
        in_valid = 1'b1;
        in_op    = op;
        in_rd    = rd;
        in_rs1   = rs1;
        in_rs2   = rs2;
        in_imm   = imm;
        waited   = 0;
        @(negedge clk);
        while (!in_ready && waited < TIMEOUT) begin
            waited++; // One stall cycle seen.
            @(negedge clk);
        end
        if (in_ready) begin
            apply_model(op, rd, rs1, rs2, imm, cyc);
        end else begin
            $display("Timeout in %s: in_ready stayed low for %0d cycles", name, waited);
            timeouts++;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_expect_stall(input string name, input op_t op,
                                     input logic [REG_ADDR_WIDTH-1:0] rd, rs1, rs2,
                                     input logic [XLEN-1:0] imm, input int stalls);
        int w;
        send_instr(name, op, rd, rs1, rs2, imm, w);
        check_value({name, " stall cycles"}, XLEN'(stalls), XLEN'(w));
    endtask

    // Drains the pipe, then compares every pulse with the model in order.
    task automatic wait_wb(input string name);
        int waited;
        waited = 0;
        while (act_data.size() < exp_data.size() && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (act_data.size() < exp_data.size()) begin
            $display("Timeout in %s: only %0d of %0d writebacks arrived", name,
                     act_data.size(), exp_data.size());
            timeouts++;
        end
        repeat (4) @(negedge clk); // Room for any pulse that should not come.
        if (act_data.size() != exp_data.size()) begin
            $display("%s saw %0d writebacks where %0d were due", name,
                     act_data.size(), exp_data.size());
            errors++;
        end
        while (act_data.size() > 0 && exp_data.size() > 0) begin
            check_value({name, " wb_rd"}, XLEN'(exp_rd.pop_front()), XLEN'(act_rd.pop_front()));
            check_value({name, " wb_data"}, exp_data.pop_front(), act_data.pop_front());
            check_value({name, " wb cycle"}, XLEN'(exp_cyc.pop_front()),
                        XLEN'(act_cyc.pop_front()));
        end
        exp_rd.delete();
        exp_data.delete();
        exp_cyc.delete();
        act_rd.delete();
        act_data.delete();
        act_cyc.delete();
        @(posedge clk);
        #1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_independent();
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        int          w;
        for (int i = 1; i <= 8; i++) begin
            next_rand(r_hi);
            next_rand(r_lo);
            send_instr("alu setup", OP_ADDI, REG_ADDR_WIDTH'(i), 5'd0, 5'd0, {r_hi, r_lo}, w);
        end
        wait_wb("alu setup");
        send_expect_stall("alu add", OP_ADD, 5'd10, 5'd1, 5'd2, '0, 0);
        send_expect_stall("alu sub", OP_SUB, 5'd11, 5'd3, 5'd4, '0, 0);
        send_expect_stall("alu and", OP_AND, 5'd12, 5'd5, 5'd6, '0, 0);
        send_expect_stall("alu or", OP_OR, 5'd13, 5'd7, 5'd8, '0, 0);
        send_expect_stall("alu xor", OP_XOR, 5'd14, 5'd1, 5'd8, '0, 0);
        wait_wb("independent alu");
    endtask

    task automatic test_forward();
        send_expect_stall("fwd head", OP_ADDI, 5'd1, 5'd0, 5'd0, 64'h123, 0);
        send_expect_stall("fwd ex rs1", OP_ADD, 5'd2, 5'd1, 5'd3, '0, 1);
        send_expect_stall("fwd ex rs2", OP_SUB, 5'd15, 5'd3, 5'd2, '0, 1);
        send_expect_stall("fwd base", OP_ADDI, 5'd4, 5'd0, 5'd0, 64'h55, 0);
        send_expect_stall("fwd filler", OP_XOR, 5'd9, 5'd5, 5'd6, '0, 0);
        send_expect_stall("fwd mem rs2", OP_AND, 5'd10, 5'd7, 5'd4, '0, 0); // From MEM.
        send_expect_stall("fwd wb both", OP_OR, 5'd11, 5'd4, 5'd4, '0, 0); // Write-through.
        wait_wb("forwarding");
    endtask

    task automatic test_store_load();
        send_expect_stall("st plain", OP_STORE, 5'd0, 5'd0, 5'd10, 64'd5, 0);
        send_expect_stall("st base", OP_ADDI, 5'd20, 5'd0, 5'd0, XLEN'(DMEM_DEPTH - 2), 0);
        send_expect_stall("st wrap", OP_STORE, 5'd0, 5'd20, 5'd11, 64'd5, 1);
        send_expect_stall("st neg", OP_STORE, 5'd0, 5'd0, 5'd12, '1, 0); // Address -1.
        send_expect_stall("ld wrap", OP_LOAD, 5'd21, 5'd0, 5'd0, 64'd3, 0);
        send_expect_stall("ld plain", OP_LOAD, 5'd22, 5'd0, 5'd0, 64'd5, 0);
        send_expect_stall("ld neg", OP_LOAD, 5'd25, 5'd20, 5'd0, XLEN'(DMEM_DEPTH + 1), 0);
        wait_wb("store load");
    endtask

    task automatic test_load_use();
        send_expect_stall("lu load", OP_LOAD, 5'd23, 5'd0, 5'd0, 64'd5, 0);
        send_expect_stall("lu use", OP_ADD, 5'd24, 5'd23, 5'd1, '0, 2);
        send_expect_stall("lu load2", OP_LOAD, 5'd26, 5'd0, 5'd0, 64'd3, 0);
        send_expect_stall("lu gap", OP_ADDI, 5'd27, 5'd0, 5'd0, 64'd1, 0);
        send_expect_stall("lu late use", OP_XOR, 5'd28, 5'd1, 5'd26, '0, 1);
        wait_wb("load use");
    endtask

    task automatic test_x0();
        send_expect_stall("x0 write", OP_ADDI, 5'd0, 5'd1, 5'd0, 64'd7, 0);
        send_expect_stall("x0 read", OP_ADD, 5'd7, 5'd0, 5'd0, '0, 0);
        send_expect_stall("x0 read2", OP_OR, 5'd8, 5'd0, 5'd2, '0, 0);
        wait_wb("x0 handling");
    endtask

    task automatic test_random_stream();
        logic [31:0] r;
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        op_t         op;
        int          w;
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            send_instr("preload", OP_STORE, 5'd0, 5'd0, REG_ADDR_WIDTH'(1 + i % 8), XLEN'(i), w);
        end
        for (int n = 0; n < 200; n++) begin
            next_rand(r);
            next_rand(r_hi);
            next_rand(r_lo);
            op = op_t'(r[2:0]);
            if (r[13:12] == 2'd0) begin
                repeat (r[15:14]) begin
                    @(posedge clk); // Idle cycle with in_valid low.
                    #1;
                end
            end
            send_instr("random stream", op, {2'b00, r[5:3]}, {2'b00, r[8:6]}, {2'b00, r[11:9]},
                       (op == OP_LOAD || op == OP_STORE) ? XLEN'(r_lo[7:0]) : {r_hi, r_lo}, w);
        end
        wait_wb("random stream");
    endtask

    initial begin
        seed     = 48598;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_op    = OP_ADD;
        in_rd    = '0;
        in_rs1   = '0;
        in_rs2   = '0;
        in_imm   = '0;
        for (int i = 0; i < (1 << REG_ADDR_WIDTH); i++) begin
            reg_model[i] = '0; // The register file resets to zero.
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("reset in_ready", '0, XLEN'(in_ready));
        check_value("reset wb_valid", '0, XLEN'(wb_valid));
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_independent();
        test_forward();
        test_store_load();
        test_load_use();
        test_x0();
        test_random_stream();
        $display("Run complete: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
logic/issue_pkg.sv
logic/issue_hazard.sv
logic/reg_file.sv
logic/data_ram.sv
logic/issue_stage.sv
logic/exec_pipe.sv
logic/issue_top.sv
testbench/tb_issue_top.sv

/* run.sh */
#!/bin/sh
# Compile and run the issue-stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_issue_top -o sim_issue
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_issue)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
